// ==== hw/core_pkg.sv ====
package core_pkg;

	// ----------------------------------------
	// word and register widths
	// ----------------------------------------
	typedef logic [31:0] word_t; // data, address and instruction
	typedef logic [4:0]  reg_addr_t;

	// major opcodes still decoded
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_t;

	// compare ops return the condition in bit 0
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_t;

	typedef enum logic {SRC_A_REG, SRC_A_PC} src_a_t;
	typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_IMM,  // lui
		WB_LINK  // pc + 4
	} wb_sel_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// ----------------------------------------
	// one word of control per instruction
	// ----------------------------------------
	typedef struct packed {
		alu_op_t alu_op;
		src_a_t  src_a;
		src_b_t  src_b;
		logic    branch;
		logic    jump;
		logic    jump_reg; // jalr
		logic    store;
		logic    load;
		logic    reg_wen;
		wb_sel_t wb_sel;
	} ctrl_t;

	localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

	// decoded form of NOP_INSTR, every enable off
	localparam ctrl_t NOP_CTRL = '{
		alu_op:   ALU_ADD,
		src_a:    SRC_A_REG,
		src_b:    SRC_B_IMM,
		branch:   1'b0,
		jump:     1'b0,
		jump_reg: 1'b0,
		store:    1'b0,
		load:     1'b0,
		reg_wen:  1'b0,
		wb_sel:   WB_ALU
	};

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import core_pkg::*;
(
	input  word_t   a_i,
	input  word_t   b_i,
	input  alu_op_t op_i,
	output word_t   result_o
);

	logic [4:0] shamt;
	logic       lt_signed, lt_unsigned, equal;

	assign shamt       = b_i[4:0];
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;
	assign equal       = a_i == b_i;

	always_comb
	begin
		result_o = '0;
		case (op_i)
			ALU_ADD:  result_o = a_i + b_i;
			ALU_SUB:  result_o = a_i - b_i;
			ALU_SLL:  result_o = a_i << shamt;
			ALU_SLT:  result_o = {31'b0, lt_signed};
			ALU_SLTU: result_o = {31'b0, lt_unsigned};
			ALU_XOR:  result_o = a_i ^ b_i;
			ALU_SRL:  result_o = a_i >> shamt;
			ALU_SRA:  result_o = $signed(a_i) >>> shamt;
			ALU_OR:   result_o = a_i | b_i;
			ALU_AND:  result_o = a_i & b_i;
			// branch conditions, bit 0 only
			ALU_EQ:   result_o = {31'b0, equal};
			ALU_NE:   result_o = {31'b0, !equal};
			ALU_LT:   result_o = {31'b0, lt_signed};
			ALU_GE:   result_o = {31'b0, !lt_signed};
			ALU_LTU:  result_o = {31'b0, lt_unsigned};
			ALU_GEU:  result_o = {31'b0, !lt_unsigned};
			default:  result_o = '0;
		endcase
	end

endmodule

// ==== hw/decoder.sv ====
`timescale 1ns/1ps

module decoder import core_pkg::*;
(
	input  word_t instr_i,
	output ctrl_t ctrl_o,
	output word_t imm_o
);

	opcode_t    opcode;
	logic [2:0] funct3;
	logic       alt; // instr bit 30, sub and sra
	word_t      imm_i_type, imm_s_type, imm_b_type, imm_u_type, imm_j_type;

	// funct3 to alu function for OP and OP_IMM
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic use_alt);
		alu_op_t op;
		case (f3)
			3'b000: op = use_alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = use_alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_t'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign alt    = instr_i[30];

	// ----------------------------------------
	// immediates, all sign extended
	// ----------------------------------------
	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_comb
	begin
		ctrl_o = NOP_CTRL; // unknown opcodes stay a nop
		imm_o  = imm_i_type;
		case (opcode)
			OPC_OP:
			begin
				ctrl_o.alu_op  = arith_op(funct3, alt);
				ctrl_o.src_b   = SRC_B_REG;
				ctrl_o.reg_wen = 1'b1;
			end
			OPC_OP_IMM:
			begin
				// only srai uses bit 30, addi has no sub form
				ctrl_o.alu_op  = arith_op(funct3, alt && funct3 == 3'b101);
				ctrl_o.reg_wen = 1'b1;
			end
			OPC_LUI:
			begin
				imm_o          = imm_u_type;
				ctrl_o.reg_wen = 1'b1;
				ctrl_o.wb_sel  = WB_IMM;
			end
			OPC_AUIPC:
			begin
				imm_o          = imm_u_type;
				ctrl_o.src_a   = SRC_A_PC;
				ctrl_o.reg_wen = 1'b1;
			end
			OPC_LOAD:
			begin
				if (funct3 == 3'b010) // lw only
				begin
					ctrl_o.load    = 1'b1;
					ctrl_o.reg_wen = 1'b1;
					ctrl_o.wb_sel  = WB_LOAD;
				end
			end
			OPC_STORE:
			begin
				imm_o = imm_s_type;
				if (funct3 == 3'b010) // sw only
					ctrl_o.store = 1'b1;
			end
			OPC_BRANCH:
			begin
				imm_o        = imm_b_type;
				ctrl_o.src_b = SRC_B_REG;
				ctrl_o.branch = 1'b1;
				case (funct3)
					3'b000: ctrl_o.alu_op = ALU_EQ;
					3'b001: ctrl_o.alu_op = ALU_NE;
					3'b100: ctrl_o.alu_op = ALU_LT;
					3'b101: ctrl_o.alu_op = ALU_GE;
					3'b110: ctrl_o.alu_op = ALU_LTU;
					3'b111: ctrl_o.alu_op = ALU_GEU;
					default: ctrl_o = NOP_CTRL;
				endcase
			end
			OPC_JAL:
			begin
				imm_o          = imm_j_type;
				ctrl_o.jump    = 1'b1;
				ctrl_o.reg_wen = 1'b1;
				ctrl_o.wb_sel  = WB_LINK;
			end
			OPC_JALR:
			begin
				ctrl_o.jump     = 1'b1;
				ctrl_o.jump_reg = 1'b1;
				ctrl_o.reg_wen  = 1'b1;
				ctrl_o.wb_sel   = WB_LINK;
			end
			default: ctrl_o = NOP_CTRL;
		endcase
	end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import core_pkg::*;
(
	input  reg_addr_t rs1_id_i,
	input  reg_addr_t rs2_id_i,
	input  reg_addr_t rs1_ex_i,
	input  reg_addr_t rs2_ex_i,
	input  reg_addr_t rd_ex_i,
	input  reg_addr_t rd_mem_i,
	input  reg_addr_t rd_wb_i,
	input  logic      load_ex_i,
	input  logic      wen_mem_i,
	input  logic      wen_wb_i,
	output fwd_sel_t  fwd_a_o,
	output fwd_sel_t  fwd_b_o,
	output logic      stall_o
);

	logic mem_writes, wb_writes;

	// mem is younger, so it wins over wb
	function automatic fwd_sel_t pick_fwd(
		input reg_addr_t rs,
		input reg_addr_t rd_mem,
		input logic      mem_ok,
		input reg_addr_t rd_wb,
		input logic      wb_ok
	);
		fwd_sel_t sel;
		if (mem_ok && rd_mem == rs)
			sel = FWD_MEM;
		else if (wb_ok && rd_wb == rs)
			sel = FWD_WB;
		else
			sel = FWD_REG;
		return sel;
	endfunction

	// x0 never forwards
	assign mem_writes = wen_mem_i && rd_mem_i != '0;
	assign wb_writes  = wen_wb_i && rd_wb_i != '0;

	always_comb
	begin
		fwd_a_o = pick_fwd(rs1_ex_i, rd_mem_i, mem_writes, rd_wb_i, wb_writes);
		fwd_b_o = pick_fwd(rs2_ex_i, rd_mem_i, mem_writes, rd_wb_i, wb_writes);
	end

	// load in ex feeding decode, one bubble
	assign stall_o = load_ex_i && rd_ex_i != '0
		&& (rd_ex_i == rs1_id_i || rd_ex_i == rs2_id_i);

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file import core_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	input  reg_addr_t rs1_i,
	input  reg_addr_t rs2_i,
	input  reg_addr_t rd_i,
	input  word_t     wdata_i,
	input  logic      wen_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

	word_t regs [1:31]; // x0 is not stored

	// falling edge write, decode sees it in the same cycle
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wen_i && rd_i != '0)
		begin
			regs[rd_i] <= wdata_i;
		end
	end

	assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== hw/core.sv ====
`timescale 1ns/1ps

module core import core_pkg::*;
#(
	parameter word_t RESET_PC = '0
)
(
	input  logic  clk_i,
	input  logic  reset_i,
	input  word_t instr_i,
	input  word_t data_i,
	output word_t instr_addr_o,
	output word_t data_addr_o,
	output word_t data_o,
	output logic  data_wen_o // active low
);

	typedef struct packed {
		word_t     pc;
		word_t     rdata1;
		word_t     rdata2;
		word_t     imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		word_t     alu;
		word_t     imm;
		word_t     link;
		reg_addr_t rd;
	} ex_mem_t;

	typedef struct packed {
		word_t     alu;
		word_t     load_data;
		word_t     imm;
		word_t     link;
		reg_addr_t rd;
	} mem_wb_t;

	// fetch
	word_t     pc_q, pc_next;
	logic      fetch_valid_q; // low until the first fetch is issued
	word_t     ifid_instr_q, ifid_pc_q;
	// decode
	ctrl_t     ctrl_id;
	word_t     imm_id, rdata1_id, rdata2_id;
	reg_addr_t rs1_id, rs2_id, rd_id;
	logic      stall;
	// execute
	ctrl_t     idex_ctrl_q;
	id_ex_t    idex_q;
	fwd_sel_t  fwd_a, fwd_b;
	word_t     op_a_fwd, op_b_fwd, alu_a, alu_b, alu_result;
	word_t     target_sum, target, link_ex;
	logic      redirect;
	// memory and writeback
	ctrl_t     exmem_ctrl_q, memwb_ctrl_q;
	ex_mem_t   exmem_q;
	mem_wb_t   memwb_q;
	word_t     mem_value, wb_value;

	function automatic word_t pick_result(
		input wb_sel_t sel,
		input word_t   alu,
		input word_t   load_data,
		input word_t   imm,
		input word_t   link
	);
		word_t res;
		case (sel)
			WB_LOAD: res = load_data;
			WB_IMM:  res = imm;
			WB_LINK: res = link;
			default: res = alu;
		endcase
		return res;
	endfunction

	function automatic word_t pick_operand(
		input fwd_sel_t sel,
		input word_t    rf,
		input word_t    mem,
		input word_t    wb
	);
		word_t res;
		case (sel)
			FWD_MEM: res = mem;
			FWD_WB:  res = wb;
			default: res = rf;
		endcase
		return res;
	endfunction

	// ----------------------------------------
	// IF
	// ----------------------------------------
	always_comb
	begin
		if (redirect)
			pc_next = target;
		else if (stall || !fetch_valid_q)
			pc_next = pc_q; // refetch same word
		else
			pc_next = pc_q + 32'd4;
	end

	assign instr_addr_o = pc_next;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q          <= RESET_PC;
			fetch_valid_q <= 1'b0;
			ifid_instr_q  <= NOP_INSTR;
		end
		else
		begin
			pc_q          <= pc_next;
			fetch_valid_q <= 1'b1;
			if (redirect || !fetch_valid_q)
				ifid_instr_q <= NOP_INSTR;
			else if (!stall)
				ifid_instr_q <= instr_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall)
			ifid_pc_q <= pc_q; // address of instr_i
	end

	// ----------------------------------------
	// ID
	// ----------------------------------------
	assign rs1_id = ifid_instr_q[19:15];
	assign rs2_id = ifid_instr_q[24:20];
	assign rd_id  = ifid_instr_q[11:7];

	decoder decoder_i (
		.instr_i (ifid_instr_q),
		.ctrl_o  (ctrl_id),
		.imm_o   (imm_id)
	);

	register_file register_file_i (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.rs1_i    (rs1_id),
		.rs2_i    (rs2_id),
		.rd_i     (memwb_q.rd),
		.wdata_i  (wb_value),
		.wen_i    (memwb_ctrl_q.reg_wen),
		.rdata1_o (rdata1_id),
		.rdata2_o (rdata2_id)
	);

	hazard_unit hazard_unit_i (
		.rs1_id_i  (rs1_id),
		.rs2_id_i  (rs2_id),
		.rs1_ex_i  (idex_q.rs1),
		.rs2_ex_i  (idex_q.rs2),
		.rd_ex_i   (idex_q.rd),
		.rd_mem_i  (exmem_q.rd),
		.rd_wb_i   (memwb_q.rd),
		.load_ex_i (idex_ctrl_q.load),
		.wen_mem_i (exmem_ctrl_q.reg_wen),
		.wen_wb_i  (memwb_ctrl_q.reg_wen),
		.fwd_a_o   (fwd_a),
		.fwd_b_o   (fwd_b),
		.stall_o   (stall)
	);

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			idex_ctrl_q <= NOP_CTRL;
		else if (redirect || stall)
			idex_ctrl_q <= NOP_CTRL; // flush or bubble
		else
			idex_ctrl_q <= ctrl_id;
	end

	always_ff @(posedge clk_i)
	begin
		idex_q <= '{pc: ifid_pc_q, rdata1: rdata1_id, rdata2: rdata2_id, imm: imm_id,
			rs1: rs1_id, rs2: rs2_id, rd: rd_id};
	end

	// ----------------------------------------
	// EX
	// ----------------------------------------
	assign op_a_fwd = pick_operand(fwd_a, idex_q.rdata1, mem_value, wb_value);
	assign op_b_fwd = pick_operand(fwd_b, idex_q.rdata2, mem_value, wb_value);
	assign alu_a    = (idex_ctrl_q.src_a == SRC_A_PC) ? idex_q.pc : op_a_fwd;
	assign alu_b    = (idex_ctrl_q.src_b == SRC_B_IMM) ? idex_q.imm : op_b_fwd;

	alu alu_i (
		.a_i      (alu_a),
		.b_i      (alu_b),
		.op_i     (idex_ctrl_q.alu_op),
		.result_o (alu_result)
	);

	// jalr adds to rs1 and drops bit 0
	assign target_sum = (idex_ctrl_q.jump_reg ? op_a_fwd : idex_q.pc) + idex_q.imm;
	assign target     = target_sum & ~{31'b0, idex_ctrl_q.jump_reg};
	assign redirect   = idex_ctrl_q.jump || (idex_ctrl_q.branch && alu_result[0]);
	assign link_ex    = idex_q.pc + 32'd4;

	// data port driven straight from EX
	assign data_addr_o = alu_result;
	assign data_o      = op_b_fwd;
	assign data_wen_o  = !idex_ctrl_q.store;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			exmem_ctrl_q <= NOP_CTRL;
			memwb_ctrl_q <= NOP_CTRL;
		end
		else
		begin
			exmem_ctrl_q <= idex_ctrl_q;
			memwb_ctrl_q <= exmem_ctrl_q;
		end
	end

	always_ff @(posedge clk_i)
	begin
		exmem_q <= '{alu: alu_result, imm: idex_q.imm, link: link_ex, rd: idex_q.rd};
		// data_i is the load word during MEM
		memwb_q <= '{alu: exmem_q.alu, load_data: data_i, imm: exmem_q.imm,
			link: exmem_q.link, rd: exmem_q.rd};
	end

	// ----------------------------------------
	// MEM and WB results
	// ----------------------------------------
	assign mem_value = pick_result(exmem_ctrl_q.wb_sel, exmem_q.alu, data_i,
		exmem_q.imm, exmem_q.link); // load word arrives on data_i in MEM
	assign wb_value  = pick_result(memwb_ctrl_q.wb_sel, memwb_q.alu, memwb_q.load_data,
		memwb_q.imm, memwb_q.link);

endmodule

// ==== tb/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ----------------------------------------
// instruction encoders
// ----------------------------------------
function automatic word_t rtype(input logic [6:0] f7, input reg_addr_t rs2, rs1,
	input logic [2:0] f3, input reg_addr_t rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t itype(input logic [11:0] imm, input reg_addr_t rs1,
	input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t stype(input logic [11:0] imm, input reg_addr_t rs2, rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
endfunction

function automatic word_t btype(input logic [12:0] off, input reg_addr_t rs2, rs1,
	input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t utype(input logic [19:0] imm, input reg_addr_t rd,
	input logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic word_t jtype(input logic [20:0] off, input reg_addr_t rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// ----------------------------------------
// program, with the store each part expects
// ----------------------------------------
task automatic build_program();
	logic [11:0] imm;
	logic [2:0]  f3;
	logic        alt;
	reg_addr_t   rs1, rs2;
	word_t       a, b, t1, t2, t3;
	prog_len = 0;
	emit(itype(12'd0, 5'd0, 3'b010, 5'd1, OPC_LOAD));
	emit(itype(12'd4, 5'd0, 3'b010, 5'd2, OPC_LOAD));
	emit(itype(12'd8, 5'd0, 3'b010, 5'd5, OPC_LOAD));
	// lw then add that needs it right away
	emit(itype(12'd16, 5'd0, 3'b010, 5'd7, OPC_LOAD));
	emit(rtype(7'h00, 5'd1, 5'd7, 3'b000, 5'd8));
	emit(stype(12'h180, 5'd8, 5'd0));
	expect_store(T_LOAD_USE, 32'h180, opnd[4] + opnd[0]);
	for (int k = 0; k < 10; k++)
	begin
		f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5); // 8 sub, 9 sra
		alt = k >= 8;
		emit(rtype(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd10));
		emit(stype(12'(256 + 4 * k), 5'd10, 5'd0));
		expect_store(T_ALU, 32'(256 + 4 * k), alu_model(f3, alt, opnd[0], opnd[1]));
	end
	for (int k = 0; k < 9; k++)
	begin
		f3  = (k < 8) ? 3'(k) : 3'd5; // 8 is srai
		alt = k == 8;
		imm = (f3 == 3'd1 || f3 == 3'd5) ? (alt ? 12'h40d : 12'd13) : 12'h9c5;
		emit(itype(imm, 5'd1, f3, 5'd10, OPC_OP_IMM));
		emit(stype(12'(320 + 4 * k), 5'd10, 5'd0));
		expect_store(T_ALU, 32'(320 + 4 * k),
			alu_model(f3, alt, opnd[0], {{20{imm[11]}}, imm}));
	end
	emit(utype(20'habcde, 5'd11, OPC_LUI));
	emit(stype(12'h170, 5'd11, 5'd0));
	expect_store(T_ALU, 32'h170, 32'habcde000);
	a = 4 * prog_len;
	emit(utype(20'h12345, 5'd12, OPC_AUIPC));
	emit(stype(12'h174, 5'd12, 5'd0));
	expect_store(T_ALU, 32'h174, 32'h12345000 + a);
	// dependent chain through MEM and WB
	emit(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd13));
	emit(rtype(7'h00, 5'd5, 5'd13, 3'b100, 5'd14));
	emit(rtype(7'h20, 5'd14, 5'd13, 3'b000, 5'd15));
	emit(rtype(7'h00, 5'd14, 5'd15, 3'b110, 5'd16));
	emit(stype(12'h190, 5'd16, 5'd0));
	emit(stype(12'h194, 5'd15, 5'd0));
	emit(stype(12'h198, 5'd14, 5'd0));
	t1 = opnd[0] + opnd[1];
	t2 = t1 ^ opnd[2];
	t3 = t1 - t2;
	expect_store(T_FORWARD, 32'h190, t3 | t2);
	expect_store(T_FORWARD, 32'h194, t3);
	expect_store(T_FORWARD, 32'h198, t2);
	emit(itype(12'hfff, 5'd0, 3'b000, 5'd21, OPC_OP_IMM)); // x21 = -1
	emit(itype(12'd1, 5'd0, 3'b000, 5'd22, OPC_OP_IMM));
	emit(itype(12'h111, 5'd0, 3'b000, 5'd24, OPC_OP_IMM)); // fall-through marker
	emit(itype(12'h222, 5'd0, 3'b000, 5'd25, OPC_OP_IMM)); // target marker
	for (int c = 0; c < 18; c++)
	begin
		f3  = (c / 3 < 2) ? 3'(c / 3) : 3'(c / 3 + 2);
		rs1 = (c % 3 == 0) ? 5'd21 : 5'd22;
		rs2 = (c % 3 == 1) ? 5'd21 : 5'd22;
		a   = (rs1 == 5'd21) ? 32'hffff_ffff : 32'd1;
		b   = (rs2 == 5'd21) ? 32'hffff_ffff : 32'd1;
		emit(btype(13'd8, rs2, rs1, f3));
		emit(stype(12'(512 + 8 * c), 5'd24, 5'd0));
		emit(stype(12'(516 + 8 * c), 5'd25, 5'd0));
		if (!branch_taken(f3, a, b))
			expect_store(T_BRANCH, 32'(512 + 8 * c), 32'h111);
		expect_store(T_BRANCH, 32'(516 + 8 * c), 32'h222);
	end
	a = 4 * prog_len;
	emit(jtype(21'd12, 5'd26));
	emit(stype(12'h2f0, 5'd24, 5'd0)); // both skipped
	emit(stype(12'h2f0, 5'd24, 5'd0));
	emit(stype(12'h2e0, 5'd26, 5'd0));
	expect_store(T_JUMP, 32'h2e0, a + 4);
	a = 4 * prog_len;
	emit(utype(20'h0, 5'd27, OPC_AUIPC));
	emit(itype(12'd17, 5'd27, 3'b000, 5'd28, OPC_JALR)); // odd offset, bit 0 dropped
	emit(stype(12'h2f4, 5'd24, 5'd0));
	emit(stype(12'h2f4, 5'd24, 5'd0));
	emit(stype(12'h2e4, 5'd28, 5'd0));
	expect_store(T_JUMP, 32'h2e4, a + 8);
	emit(itype(12'd1, 5'd0, 3'b000, 5'd29, OPC_OP_IMM));
	emit(stype(12'h3fc, 5'd29, 5'd0));
	expect_store(T_DONE, 32'h3fc, 32'd1);
	emit(jtype(21'd0, 5'd0)); // park here
endtask

`endif

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core import core_pkg::*;
();

	localparam int T_RESET    = 0;
	localparam int T_LOAD_USE = 1;
	localparam int T_ALU      = 2;
	localparam int T_FORWARD  = 3;
	localparam int T_BRANCH   = 4;
	localparam int T_JUMP     = 5;
	localparam int T_DONE     = 6;
	localparam word_t DONE_ADDR = 32'h3fc;

	typedef struct packed {
		logic [2:0] test;
		word_t      addr;
		word_t      data;
	} store_t;

	logic   clk_i, reset_i, data_wen_o;
	word_t  instr_i, data_i, instr_addr_o, data_addr_o, data_o;
	word_t  rom [0:255];
	word_t  ram [0:255];
	word_t  opnd [0:7];
	word_t  instr_addr_q, data_addr_q;
	store_t expect_q [$];
	logic [31:0] lfsr;
	logic   done;
	int     prog_len, cycles, limit;
	int     test_errors, errors, passed, failed;

	`include "tb_program.svh"

	core #(.RESET_PC(32'h0)) core_i (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.instr_i      (instr_i),
		.data_i       (data_i),
		.instr_addr_o (instr_addr_o),
		.data_addr_o  (data_addr_o),
		.data_o       (data_o),
		.data_wen_o   (data_wen_o)
	);

	// ----------------------------------------
	// reference model and helpers
	// ----------------------------------------
	function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// fibonacci, taps 32 22 2 1
	function automatic logic lfsr_step();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic string test_name(input int t);
		case (t)
			T_RESET:    return "reset";
			T_LOAD_USE: return "load_use";
			T_ALU:      return "alu";
			T_FORWARD:  return "forwarding";
			T_BRANCH:   return "branches";
			T_JUMP:     return "jumps";
			default:    return "done_store";
		endcase
	endfunction

	task automatic emit(input word_t w);
		rom[prog_len] = w;
		prog_len++;
	endtask

	task automatic expect_store(input int t, input word_t a, input word_t d);
		expect_q.push_back('{test: 3'(t), addr: a, data: d});
	endtask

	task automatic finish_test(input int t);
		if (test_errors == 0)
		begin
			$display("test %-10s ok", test_name(t));
			passed++;
		end
		else
		begin
			$display("test %-10s %0d mismatches", test_name(t), test_errors);
			failed++;
		end
		test_errors = 0;
	endtask

	task automatic check_store(input word_t addr, input word_t data);
		store_t e, nxt;
		if (expect_q.size() == 0)
		begin
			$display("store of %h to address %h was not expected", data, addr);
			errors++;
		end
		else
		begin
			e = expect_q.pop_front();
			assert (addr == e.addr)
			else
			begin
				$display("[FAIL] %s address: expected %h, actual %h", test_name(e.test),
					e.addr, addr);
				test_errors++;
			end
			assert (data == e.data)
			else
			begin
				$display("[FAIL] %s data at %h: expected %h, actual %h", test_name(e.test),
					e.addr, e.data, data);
				test_errors++;
			end
			if (addr == DONE_ADDR)
				done = 1'b1;
			if (expect_q.size() > 0)
				nxt = expect_q[0];
			if (expect_q.size() == 0 || nxt.test != e.test)
				finish_test(e.test);
		end
	endtask

	// ----------------------------------------
	// clock and memories
	// ----------------------------------------
	initial
	begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i)
	begin
		instr_addr_q <= instr_addr_o;
		data_addr_q  <= data_addr_o;
		if (!data_wen_o)
			ram[data_addr_o[9:2]] <= data_o; // full word only
		if (reset_i && !data_wen_o)
			check_store(data_addr_o, data_o);
	end

	// read data shows up on the falling edge
	always @(negedge clk_i)
	begin
		instr_i <= rom[instr_addr_q[9:2]];
		data_i  <= ram[data_addr_q[9:2]];
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		reset_i      = 1'b0;
		instr_i      = NOP_INSTR;
		data_i       = '0;
		instr_addr_q = '0;
		data_addr_q  = '0;
		done         = 1'b0;
		lfsr         = 32'h4b9d_d29e;
		{test_errors, errors, passed, failed, cycles} = '0;
		for (int i = 0; i < 256; i++)
		begin
			rom[i] = NOP_INSTR;
			ram[i] = {24'h5a5a5a, 8'(i)};
		end
		for (int i = 0; i < 8; i++)
		begin
			for (int j = 0; j < 32; j++)
				opnd[i] = {opnd[i][30:0], lfsr_step()};
			ram[i] = opnd[i];
		end
		build_program();
		limit = prog_len * 3 + 100; // worst case three cycles each, plus pipeline fill

		repeat (16)
		begin
			@(negedge clk_i);
			assert (data_wen_o === 1'b1)
			else
			begin
				$display("[FAIL] reset data_wen_o: expected 1, actual %b", data_wen_o);
				test_errors++;
			end
			assert (instr_addr_o === 32'h0)
			else
			begin
				$display("[FAIL] reset instr_addr_o: expected %h, actual %h", 32'h0,
					instr_addr_o);
				test_errors++;
			end
		end
		reset_i = 1'b1;
		finish_test(T_RESET);

		while (!done && cycles < limit)
		begin
			@(negedge clk_i);
			cycles++;
		end
		repeat (8) @(negedge clk_i); // catch stray stores after done
		if (!done)
		begin
			$display("timeout, the done store did not arrive within %0d cycles", limit);
			errors++;
		end
		if (expect_q.size() != 0)
		begin
			$display("%0d expected stores never reached memory", expect_q.size());
			errors++;
		end
		$display("%0d tests passed, %0d tests failed, %0d other errors", passed, failed,
			errors);
		if (failed == 0 && errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+tb
hw/core_pkg.sv
hw/alu.sv
hw/decoder.sv
hw/hazard_unit.sv
hw/register_file.sv
hw/core.sv
tb/tb_core.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - files:
      - hw/core_pkg.sv
      - hw/alu.sv
      - hw/decoder.sv
      - hw/hazard_unit.sv
      - hw/register_file.sv
      - hw/core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_core.sv
